/* Makefile */
SIM  := obj_dir/Vaw_arbiter_tb
SRCS := $(wildcard source/*.sv dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
	    --top-module aw_arbiter_tb -f vlog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Simulation failed" sim.log || \
	    ! grep -q "Simulation completed successfully" sim.log; then \
	    echo "RUN FAILED"; \
	    exit 1; \
	else \
	    echo "RUN PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log

/* dv/aw_arbiter_chk.sv */
`timescale 1ns/1ns

module aw_arbiter_chk (
    input logic                     clk,
    input logic                     rst,
    input arb_types_pkg::arb_mode_t mode,
    input arb_types_pkg::req_vec_t  awvalid,
    input arb_types_pkg::req_vec_t  m_sel
);

    ////////////////////////////////////////////////////////////
    // Output shape
    ////////////////////////////////////////////////////////////

    sel_onehot0: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(m_sel)
    ) else $error("m_sel has more than one master selected: %b", m_sel);

    ////////////////////////////////////////////////////////////
    // Grants trace back to requests
    ////////////////////////////////////////////////////////////

    // Fixed grant is combinational with one register to m_sel
    sel_requested_fixed: assert property (
        @(posedge clk) disable iff (rst)
        ($past(mode) == arb_types_pkg::MODE_FIXED)
            |-> ((m_sel & ~$past(awvalid)) == '0)
    ) else $error("m_sel %b selects a master with no request in fixed mode", m_sel);

    // LRG path has its own grant register in front of m_sel
    sel_requested_lrg: assert property (
        @(posedge clk) disable iff (rst)
        ($past(mode) == arb_types_pkg::MODE_LRG)
            |-> ((m_sel & ~$past(awvalid, 2)) == '0)
    ) else $error("m_sel %b selects a master with no request in LRG mode", m_sel);

    ////////////////////////////////////////////////////////////
    // Reset
    ////////////////////////////////////////////////////////////

    sel_cleared_by_reset: assert property (
        @(posedge clk)
        ($past(rst) && !rst) |-> (m_sel == '0)
    ) else $error("m_sel not zero on the first edge after reset: %b", m_sel);

endmodule

bind aw_arbiter aw_arbiter_chk aw_arbiter_chk_inst (
    .clk     (clk),
    .rst     (rst),
    .mode    (mode),
    .awvalid (awvalid),
    .m_sel   (m_sel)
);

/* dv/aw_arbiter_tb.sv */
`timescale 1ns/1ns

module aw_arbiter_tb;

    localparam int NM        = arb_cfg_pkg::NUM_MASTERS;
    localparam int AGE_LIMIT = arb_cfg_pkg::AGE_LIMIT_DEFAULT;
    localparam int AGE_MAX   = (1 << arb_cfg_pkg::AGE_W) - 1;

    logic                     clk = 1'b0;
    logic                     rst;
    arb_types_pkg::arb_mode_t mode;
    arb_types_pkg::req_vec_t  awvalid;
    arb_types_pkg::req_vec_t  m_sel;

    // Reference model state
    int                      mdl_age [$];
    int                      mdl_rank [$];   // Front is highest rank
    int                      mdl_fav;
    arb_types_pkg::req_vec_t mdl_lrg;
    arb_types_pkg::req_vec_t exp_sel;

    logic [31:0] lcg_state = 32'hccb4_56f6;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_num = 0;

    aw_arbiter #(
        .AGE_LIMIT(AGE_LIMIT)
    ) aw_arbiter_inst (
        .clk     (clk),
        .rst     (rst),
        .mode    (mode),
        .awvalid (awvalid),
        .m_sel   (m_sel)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic arb_types_pkg::req_vec_t onehot(input int idx);
        return arb_types_pkg::req_vec_t'(1) << idx;
    endfunction

    function automatic logic bit_of(input arb_types_pkg::req_vec_t v, input int idx);
        arb_types_pkg::req_vec_t t;
        t = v >> idx;
        return t[0];
    endfunction

    function automatic int index_of(input arb_types_pkg::req_vec_t v);
        int idx;
        idx = -1;
        for (int i = NM - 1; i >= 0; i--) begin
            if (bit_of(v, i)) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Favored master first or else the lowest index
    function automatic arb_types_pkg::req_vec_t fixed_choice(
        input arb_types_pkg::req_vec_t req,
        input int                      fav
    );
        int low;
        if (bit_of(req, fav)) begin
            return onehot(fav);
        end
        low = index_of(req);
        return (low < 0) ? '0 : onehot(low);
    endfunction

    // Unique largest counter above the limit or 0 when none
    function automatic int overdue_master();
        int top;
        int top_idx;
        int ties;
        top     = 0;
        top_idx = 0;
        ties    = 0;
        for (int i = 0; i < NM; i++) begin
            if (mdl_age[i] > top) begin
                top     = mdl_age[i];
                top_idx = i;
                ties    = 1;
            end else if (mdl_age[i] == top) begin
                ties++;
            end
        end
        return (top > AGE_LIMIT && ties == 1) ? top_idx : 0;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic random_req(output arb_types_pkg::req_vec_t v);
        lcg_state = lcg_next(lcg_state);
        v = lcg_state[21:16];
    endtask

    task automatic idle(input int cycles);
        awvalid = '0;
        repeat (cycles) next_cycle();
    endtask

    task automatic wait_for_sel(input arb_types_pkg::req_vec_t target, input int max_cycles);
        int n;
        n = 0;
        while (m_sel !== target && n < max_cycles) begin
            next_cycle();
            n++;
        end
        if (m_sel !== target) begin
            $display("Timeout at t=%0t: m_sel did not reach %b within %0d cycles",
                     $time, target, max_cycles);
            error_count++;
        end
    endtask

    task automatic wait_for_grant(input int max_cycles);
        int n;
        n = 0;
        while (m_sel == '0 && n < max_cycles) begin
            next_cycle();
            n++;
        end
        if (m_sel == '0) begin
            $display("Timeout at t=%0t: no master selected within %0d cycles",
                     $time, max_cycles);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        test_num++;
        if (error_count == errs_at_start) begin
            pass_count++;
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            fail_count++;
            $display("Test %0d %s: failed with %0d errors", test_num, name,
                     error_count - errs_at_start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model of both schemes
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : ref_model
        arb_types_pkg::req_vec_t fix_g;
        int od;
        int pos;
        int who;
        if (rst) begin
            mdl_age.delete();
            mdl_rank.delete();
            for (int i = 0; i < NM; i++) begin
                mdl_age.push_back(0);
                mdl_rank.push_back(i);
            end
            mdl_fav = 0;
            mdl_lrg = '0;
            exp_sel = '0;
        end else begin
            fix_g   = fixed_choice(awvalid, mdl_fav);
            exp_sel = (mode == arb_types_pkg::MODE_FIXED) ? fix_g : mdl_lrg;
            od      = overdue_master();   // From counters before this edge
            for (int i = 1; i < NM; i++) begin
                if (bit_of(awvalid, i) && !bit_of(fix_g, i)) begin
                    if (mdl_age[i] < AGE_MAX) begin
                        mdl_age[i] = mdl_age[i] + 1;
                    end
                end else begin
                    mdl_age[i] = 0;
                end
            end
            if (od > 0 && od != mdl_fav) begin
                mdl_fav = od;
            end else if (mdl_fav != 0 && !bit_of(awvalid, mdl_fav)) begin
                mdl_fav = 0;
            end
            if (mdl_lrg == '0) begin
                pos = -1;
                for (int k = NM - 1; k >= 0; k--) begin
                    if (bit_of(awvalid, mdl_rank[k])) begin
                        pos = k;
                    end
                end
                if (pos >= 0) begin
                    who     = mdl_rank[pos];
                    mdl_lrg = onehot(who);
                    mdl_rank.delete(pos);
                    mdl_rank.push_back(who);
                end
            end else if ((awvalid & mdl_lrg) == '0) begin
                mdl_lrg = '0;
            end
        end
    end

    always @(negedge clk) begin
        assert (m_sel === exp_sel) else begin
            $display("[ERROR] t=%0t m_sel expected %b actual %b", $time, exp_sel, m_sel);
            error_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        int start;
        start = error_count;
        rst = 1'b1;
        repeat (4) begin
            random_req(awvalid);
            mode = lcg_state[27] ? arb_types_pkg::MODE_LRG : arb_types_pkg::MODE_FIXED;
            next_cycle();
        end
        rst = 1'b0;   // awvalid stays random across the release edge
        next_cycle();
        mode = arb_types_pkg::MODE_FIXED;
        idle(3);
        report_test("reset", start);
    endtask

    task automatic test_fixed_order();
        int start;
        start = error_count;
        mode = arb_types_pkg::MODE_FIXED;
        for (int g = 0; g < 40; g++) begin
            repeat (3) begin
                random_req(awvalid);
                next_cycle();
            end
            idle(1);   // Clears every wait counter
        end
        idle(2);
        report_test("fixed order", start);
    endtask

    task automatic test_aging();
        int start;
        start = error_count;
        mode = arb_types_pkg::MODE_FIXED;
        awvalid = 6'b001001;
        wait_for_sel(6'b001000, AGE_LIMIT + 4);
        repeat (6) next_cycle();
        awvalid = 6'b000001;
        wait_for_sel(6'b000001, 1);
        idle(3);
        report_test("aging promotion", start);
    endtask

    task automatic test_lrg_hold();
        int start;
        start = error_count;
        rst = 1'b1;
        idle(4);
        rst = 1'b0;
        mode = arb_types_pkg::MODE_LRG;
        awvalid = 6'b100000;
        wait_for_sel(6'b100000, 3);
        repeat (5) next_cycle();
        awvalid = '0;
        wait_for_sel('0, 2);
        idle(2);
        report_test("lrg hold and release", start);
    endtask

    task automatic test_lrg_rotation();
        int start;
        int order [$];
        int idx;
        start = error_count;
        order = mdl_rank;
        mode = arb_types_pkg::MODE_LRG;
        awvalid = '1;
        for (int n = 0; n <= NM; n++) begin
            wait_for_grant(6);
            idx = index_of(m_sel);
            assert (idx == order[n % NM]) else begin
                $display("[ERROR] t=%0t m_sel expected %b actual %b",
                         $time, onehot(order[n % NM]), m_sel);
                error_count++;
            end
            if (idx >= 0) begin
                awvalid = awvalid & ~onehot(idx);
            end
            next_cycle();
            awvalid = '1;
            wait_for_sel('0, 4);
        end
        idle(3);
        report_test("lrg rotation", start);
    endtask

    task automatic test_mode_switch();
        int start;
        int p;
        arb_types_pkg::req_vec_t tgt_lrg;
        start = error_count;
        for (int r = 0; r < 2; r++) begin
            // First rank slot out of index order holds a master LRG puts ahead of a lower index
            p = 0;
            while (p < NM - 1 && mdl_rank[p] == p) begin
                p++;
            end
            mode = arb_types_pkg::MODE_FIXED;
            awvalid = onehot(p) | onehot(mdl_rank[p]);
            wait_for_sel(fixed_choice(awvalid, mdl_fav), 3);
            tgt_lrg = mdl_lrg;
            mode = arb_types_pkg::MODE_LRG;
            wait_for_sel(tgt_lrg, 2);
            mode = arb_types_pkg::MODE_FIXED;
            wait_for_sel(fixed_choice(awvalid, mdl_fav), 2);
            idle(3);
        end
        report_test("mode switch", start);
    endtask

    initial begin
        rst     = 1'b1;
        mode    = arb_types_pkg::MODE_FIXED;
        awvalid = '0;

        test_reset();
        test_fixed_order();
        test_aging();
        test_lrg_hold();
        test_lrg_rotation();
        test_mode_switch();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* source/aged_priority_arbiter.sv */
`timescale 1ns/1ns

module aged_priority_arbiter #(
    parameter int AGE_LIMIT = 9
) (
    input  logic                    clk,
    input  logic                    rst,
    input  arb_types_pkg::req_vec_t awvalid,
    output arb_types_pkg::req_vec_t grant
);

    localparam int N    = arb_cfg_pkg::NUM_MASTERS;
    localparam int ST_W = $bits(arb_types_pkg::favor_state_t);

    arb_types_pkg::favor_state_t state;
    arb_types_pkg::favor_state_t state_next;
    arb_types_pkg::favor_state_t promote_to;
    arb_types_pkg::req_vec_t     overdue;
    logic                        promote;

    aging_counters #(
        .AGE_LIMIT(AGE_LIMIT)
    ) aging_counters_inst (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .grant   (grant),
        .overdue (overdue)
    );

    ////////////////////////////////////////////////////////////
    // Favored-master FSM
    ////////////////////////////////////////////////////////////

    // At most one overdue bit, so order of the scan does not matter
    always_comb begin
        promote    = 1'b0;
        promote_to = arb_types_pkg::FAVOR_M0;
        for (int i = 1; i < N; i++) begin
            if (overdue[i] && i != int'(state)) begin
                promote    = 1'b1;
                promote_to = arb_types_pkg::favor_state_t'(ST_W'(i));
            end
        end
    end

    always_comb begin
        if (promote) begin
            state_next = promote_to;
        end else if (state != arb_types_pkg::FAVOR_M0 && !awvalid[state]) begin
            state_next = arb_types_pkg::FAVOR_M0;  // Favored master let go
        end else begin
            state_next = state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_types_pkg::FAVOR_M0;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Grant
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (awvalid[state]) begin
            grant = arb_types_pkg::req_vec_t'(1) << state;
        end else begin
            // Lowest-index requester or zero when idle
            grant = awvalid & (~awvalid + arb_types_pkg::req_vec_t'(1));
        end
    end

endmodule

/* source/aging_counters.sv */
`timescale 1ns/1ns

module aging_counters #(
    parameter int AGE_LIMIT = 9
) (
    input  logic                    clk,
    input  logic                    rst,
    input  arb_types_pkg::req_vec_t awvalid,
    input  arb_types_pkg::req_vec_t grant,
    output arb_types_pkg::req_vec_t overdue
);

    localparam int N = arb_cfg_pkg::NUM_MASTERS;
    localparam arb_types_pkg::age_t LIMIT = arb_types_pkg::age_t'(AGE_LIMIT);

    arb_types_pkg::age_vec_t ages;

    // Past the limit and strictly ahead of every other counter
    function automatic logic is_overdue(input arb_types_pkg::age_vec_t a, input int idx);
        logic win;
        win = (a[idx] > LIMIT);
        for (int j = 0; j < N; j++) begin
            if (j != idx && a[idx] <= a[j]) begin
                win = 1'b0;
            end
        end
        return win;
    endfunction

    ////////////////////////////////////////////////////////////
    // Wait counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ages <= '0;
        end else begin
            ages[0] <= '0;  // Master 0 is favored by default and never ages
            for (int i = 1; i < N; i++) begin
                if (awvalid[i] && !grant[i]) begin
                    if (ages[i] != '1) begin
                        ages[i] <= ages[i] + 1'b1;  // Saturate at max
                    end
                end else begin
                    ages[i] <= '0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Overdue detector
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            overdue[i] = is_overdue(ages, i);
        end
    end

endmodule

/* source/arb_cfg_pkg.sv */
package arb_cfg_pkg;

    // Write-address request lines
    localparam int NUM_MASTERS = 6;

    localparam int AGE_W = 4;              // Bits per wait counter

    // Wait beyond this many cycles promotes a master
    localparam int AGE_LIMIT_DEFAULT = 9;

endpackage

/* source/arb_types_pkg.sv */
package arb_types_pkg;

    // One bit per master for requests, grants, overdue flags and ranks
    typedef logic [arb_cfg_pkg::NUM_MASTERS-1:0] req_vec_t;

    typedef logic [arb_cfg_pkg::AGE_W-1:0] age_t;

    typedef age_t [arb_cfg_pkg::NUM_MASTERS-1:0] age_vec_t;  // All wait counters

    // Currently favored master in fixed mode
    typedef enum logic [2:0] {
        FAVOR_M0 = 3'd0,
        FAVOR_M1 = 3'd1,
        FAVOR_M2 = 3'd2,
        FAVOR_M3 = 3'd3,
        FAVOR_M4 = 3'd4,
        FAVOR_M5 = 3'd5
    } favor_state_t;

    typedef enum logic {MODE_FIXED = 1'b0, MODE_LRG = 1'b1} arb_mode_t;

endpackage

/* source/aw_arbiter.sv */
`timescale 1ns/1ns

module aw_arbiter #(
    parameter int AGE_LIMIT = arb_cfg_pkg::AGE_LIMIT_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst,
    input  arb_types_pkg::arb_mode_t mode,
    input  arb_types_pkg::req_vec_t  awvalid,
    output arb_types_pkg::req_vec_t  m_sel
);

    arb_types_pkg::req_vec_t fixed_grant;
    arb_types_pkg::req_vec_t lrg_grant;

    // Both schemes run all the time
    aged_priority_arbiter #(
        .AGE_LIMIT(AGE_LIMIT)
    ) aged_priority_arbiter_inst (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .grant   (fixed_grant)
    );

    lrg_arbiter lrg_arbiter_inst (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .grant   (lrg_grant)
    );

    // Output register
    always_ff @(posedge clk) begin
        if (rst) begin
            m_sel <= '0;
        end else if (mode == arb_types_pkg::MODE_FIXED) begin
            m_sel <= fixed_grant;
        end else begin
            m_sel <= lrg_grant;
        end
    end

endmodule

/* source/lrg_arbiter.sv */
`timescale 1ns/1ns

module lrg_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  arb_types_pkg::req_vec_t awvalid,
    output arb_types_pkg::req_vec_t grant
);

    localparam int N     = arb_cfg_pkg::NUM_MASTERS;
    localparam int IDX_W = $clog2(N);

    // rank[0] is highest priority and each entry is one-hot
    arb_types_pkg::req_vec_t rank [N];

    logic             found;
    logic [IDX_W-1:0] win_idx;

    ////////////////////////////////////////////////////////////
    // Highest-ranked requester
    ////////////////////////////////////////////////////////////

    always_comb begin
        found   = 1'b0;
        win_idx = '0;
        for (int k = N - 1; k >= 0; k--) begin  // Downward so the top rank wins
            if (|(awvalid & rank[k])) begin
                found   = 1'b1;
                win_idx = IDX_W'(k);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Grant and rank update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
            for (int i = 0; i < N; i++) begin
                rank[i] <= arb_types_pkg::req_vec_t'(1) << i;
            end
        end else if (grant == '0) begin
            if (found) begin
                grant <= rank[win_idx];
                // Winner drops to the bottom and the ranks below it move up
                for (int j = 0; j < N - 1; j++) begin
                    if (j >= int'(win_idx)) begin
                        rank[j] <= rank[j+1];
                    end
                end
                rank[N-1] <= rank[win_idx];
            end
        end else if ((awvalid & grant) == '0) begin
            grant <= '0;  // Request released
        end
    end

endmodule

/* vlog.f */
source/arb_cfg_pkg.sv
source/arb_types_pkg.sv
source/aging_counters.sv
source/aged_priority_arbiter.sv
source/lrg_arbiter.sv
source/aw_arbiter.sv
dv/aw_arbiter_chk.sv
dv/aw_arbiter_tb.sv
